/* source/rob_pkg.sv */
package rob_pkg;

	// ========================================================================
	// reorder buffer geometry
	// ========================================================================

	// number of entries, must be a power of two
	localparam int ROB_SZ = 16;

	// index width, log2 of ROB_SZ
	localparam int ROB_IDX = 4;

	// ========================================================================
	// register files
	// ========================================================================

	// 64 physical registers
	localparam int PRF_IDX = 6;

	// 32 architectural registers
	localparam int ARF_IDX = 5;
	localparam int ARF_SZ = 32;

	// ========================================================================
	// datapath
	// ========================================================================

	// pc and branch address width
	localparam int XLEN = 64;

	// instruction word
	localparam int IR_W = 32;

endpackage

/* source/cb.sv */
`timescale 1ns/1ps

// one field of the rob payload, kept as a two-wide circular array
// head and tail follow the pointers inside rob exactly
module cb
	import rob_pkg::*;
#(
	parameter int cb_width = 32
) (
	input logic clk,
	input logic reset,

	// write side, already gated by full and flush
	input logic alloc1_en,
	input logic alloc2_en,

	// read side, retire counts from rob
	input logic retire1,
	input logic retire2,

	// flush on branch miss
	input logic rewind,
	input logic [ROB_IDX-1:0] tail_new,

	input logic [cb_width-1:0] din1,
	input logic [cb_width-1:0] din2,

	output logic [cb_width-1:0] dout1,
	output logic [cb_width-1:0] dout2
);

	logic [cb_width-1:0] mem [ROB_SZ];

	logic [ROB_IDX-1:0] head;
	logic [ROB_IDX-1:0] tail;
	logic [ROB_IDX-1:0] head_p1;
	logic [ROB_IDX-1:0] tail_p1;
	logic [ROB_IDX-1:0] next_head;
	logic [ROB_IDX-1:0] next_tail;

	assign head_p1 = head + ROB_IDX'(1);
	assign tail_p1 = tail + ROB_IDX'(1);

	// ========================================================================
	// pointer update
	// ========================================================================

	always_comb begin
		next_head = head;
		if (retire1) begin
			next_head = head_p1;
			if (retire2) begin
				next_head = head + ROB_IDX'(2);
			end
		end
	end

	always_comb begin
		next_tail = tail;
		if (rewind) begin
			next_tail = tail_new;
		end else if (alloc1_en) begin
			next_tail = tail_p1;
			if (alloc2_en) begin
				next_tail = tail + ROB_IDX'(2);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
		end else begin
			head <= next_head;
			tail <= next_tail;
		end
	end

	// ========================================================================
	// storage
	// ========================================================================

	// no writes in a flush cycle
	always_ff @(posedge clk) begin
		if (!rewind && alloc1_en) begin
			mem[tail] <= din1;
			if (alloc2_en) begin
				mem[tail_p1] <= din2;
			end
		end
	end

	// oldest two entries
	assign dout1 = mem[head];
	assign dout2 = mem[head_p1];

endmodule

/* source/rob.sv */
`timescale 1ns/1ps

module rob
	import rob_pkg::*;
(
	input logic clk,
	input logic reset,

	// allocation, in program order
	input logic alloc1_req,
	input logic alloc2_req,
	input logic [IR_W-1:0] ir_in1,
	input logic [IR_W-1:0] ir_in2,
	input logic [XLEN-1:0] npc_in1,
	input logic [XLEN-1:0] npc_in2,
	input logic [PRF_IDX-1:0] pdest_in1,
	input logic [PRF_IDX-1:0] pdest_in2,
	input logic [ARF_IDX-1:0] adest_in1,
	input logic [ARF_IDX-1:0] adest_in2,
	input logic bt_pd_in1,
	input logic bt_pd_in2,
	input logic [XLEN-1:0] ba_pd_in1,
	input logic [XLEN-1:0] ba_pd_in2,
	input logic isbranch_in1,
	input logic isbranch_in2,

	// completion
	input logic upd1_req,
	input logic upd2_req,
	input logic [ROB_IDX-1:0] rob_idx_in1,
	input logic [ROB_IDX-1:0] rob_idx_in2,
	input logic bt_ex_in1,
	input logic bt_ex_in2,
	input logic [XLEN-1:0] ba_ex_in1,
	input logic [XLEN-1:0] ba_ex_in2,

	// indices handed to the new entries
	output logic [ROB_IDX-1:0] rob_idx_out1,
	output logic [ROB_IDX-1:0] rob_idx_out2,
	output logic [ROB_IDX-1:0] head,

	// retirement
	output logic retire1_valid,
	output logic retire2_valid,
	output logic [IR_W-1:0] ir_out1,
	output logic [IR_W-1:0] ir_out2,
	output logic [XLEN-1:0] npc_out1,
	output logic [XLEN-1:0] npc_out2,
	output logic [PRF_IDX-1:0] pdest_out1,
	output logic [PRF_IDX-1:0] pdest_out2,
	output logic [ARF_IDX-1:0] adest_out1,
	output logic [ARF_IDX-1:0] adest_out2,

	// branch resolution, slot 1 in the upper half
	output logic branch_miss,
	output logic [XLEN-1:0] correct_target,
	output logic [1:0] isbranch_out,
	output logic [1:0] bt_out,
	output logic [2*XLEN-1:0] ba_out,

	output logic full,
	output logic full_almost
);

	// per-entry completion state
	logic [ROB_SZ-1:0] rdy;
	logic [ROB_SZ-1:0] bt_ex;
	logic [XLEN-1:0] ba_ex [ROB_SZ];

	logic [ROB_IDX-1:0] tail;
	logic [ROB_IDX-1:0] head_p1;
	logic [ROB_IDX-1:0] tail_p1;
	logic [ROB_IDX-1:0] next_head;
	logic [ROB_IDX-1:0] next_tail;
	logic [ROB_IDX:0] count;
	logic [ROB_IDX:0] next_count;
	logic [ROB_IDX:0] in_cnt;
	logic [ROB_IDX:0] out_cnt;

	logic alloc1_en;
	logic alloc2_en;
	logic empty;
	logic two_plus;
	logic miss1;
	logic miss2;

	// predictions read back from the payload buffers
	logic bt_pd_out1;
	logic bt_pd_out2;
	logic [XLEN-1:0] ba_pd_out1;
	logic [XLEN-1:0] ba_pd_out2;
	logic isbranch_out1;
	logic isbranch_out2;

	assign head_p1 = head + ROB_IDX'(1);
	assign tail_p1 = tail + ROB_IDX'(1);
	assign empty = (count == '0);
	assign two_plus = (count > (ROB_IDX+1)'(1));

	assign rob_idx_out1 = tail;
	assign rob_idx_out2 = tail_p1;

	// ========================================================================
	// retirement and misprediction
	// ========================================================================

	assign miss1 = isbranch_out1 && ((bt_ex[head] != bt_pd_out1) || (ba_ex[head] != ba_pd_out1));
	assign miss2 = isbranch_out2 &&
		((bt_ex[head_p1] != bt_pd_out2) || (ba_ex[head_p1] != ba_pd_out2));

	assign retire1_valid = !empty && rdy[head];
	assign branch_miss = retire1_valid && miss1;

	// a slot 2 miss waits one cycle to reach slot 1
	assign retire2_valid = retire1_valid && !branch_miss && two_plus && rdy[head_p1] && !miss2;

	assign correct_target = branch_miss ? ba_ex[head] : '0;

	assign isbranch_out = {isbranch_out1, isbranch_out2};
	assign bt_out = {bt_ex[head], bt_ex[head_p1]};
	assign ba_out = {ba_ex[head], ba_ex[head_p1]};

	// ========================================================================
	// allocation and occupancy
	// ========================================================================

	assign alloc1_en = alloc1_req && !full && !branch_miss;
	assign alloc2_en = alloc1_en && alloc2_req && !full_almost;

	assign in_cnt = (ROB_IDX+1)'(alloc1_en) + (ROB_IDX+1)'(alloc2_en);
	assign out_cnt = (ROB_IDX+1)'(retire1_valid) + (ROB_IDX+1)'(retire2_valid);

	assign next_head = head + out_cnt[ROB_IDX-1:0];

	// flush leaves the tail just behind the retiring branch
	assign next_tail = branch_miss ? head_p1 : tail + in_cnt[ROB_IDX-1:0];

	// after a flush the count comes from the pointers again
	assign next_count = branch_miss ? {1'b0, next_tail - next_head} : count + in_cnt - out_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			full <= 1'b0;
			full_almost <= 1'b0;
		end else begin
			head <= next_head;
			tail <= next_tail;
			count <= next_count;
			full <= (next_count == (ROB_IDX+1)'(ROB_SZ));
			full_almost <= (next_count == (ROB_IDX+1)'(ROB_SZ-1));
		end
	end

	// ========================================================================
	// completion storage
	// ========================================================================

	// ready bits, cleared on allocation, set on completion
	always_ff @(posedge clk) begin
		if (reset) begin
			rdy <= '0;
		end else begin
			if (alloc1_en) begin
				rdy[tail] <= 1'b0;
			end
			if (alloc2_en) begin
				rdy[tail_p1] <= 1'b0;
			end
			if (upd1_req) begin
				rdy[rob_idx_in1] <= 1'b1;
				if (upd2_req) begin
					rdy[rob_idx_in2] <= 1'b1;
				end
			end
		end
	end

	// resolved direction and address
	always_ff @(posedge clk) begin
		if (alloc1_en) begin
			bt_ex[tail] <= 1'b0;
			ba_ex[tail] <= '0;
		end
		if (alloc2_en) begin
			bt_ex[tail_p1] <= 1'b0;
			ba_ex[tail_p1] <= '0;
		end
		if (upd1_req) begin
			bt_ex[rob_idx_in1] <= bt_ex_in1;
			ba_ex[rob_idx_in1] <= ba_ex_in1;
			if (upd2_req) begin
				bt_ex[rob_idx_in2] <= bt_ex_in2;
				ba_ex[rob_idx_in2] <= ba_ex_in2;
			end
		end
	end

	// ========================================================================
	// payload buffers
	// ========================================================================

	cb #(.cb_width(IR_W)) cb_ir (
		.clk(clk), .reset(reset), .alloc1_en(alloc1_en), .alloc2_en(alloc2_en),
		.retire1(retire1_valid), .retire2(retire2_valid), .rewind(branch_miss),
		.tail_new(head_p1), .din1(ir_in1), .din2(ir_in2), .dout1(ir_out1), .dout2(ir_out2)
	);

	cb #(.cb_width(XLEN)) cb_npc (
		.clk(clk), .reset(reset), .alloc1_en(alloc1_en), .alloc2_en(alloc2_en),
		.retire1(retire1_valid), .retire2(retire2_valid), .rewind(branch_miss),
		.tail_new(head_p1), .din1(npc_in1), .din2(npc_in2), .dout1(npc_out1), .dout2(npc_out2)
	);

	cb #(.cb_width(PRF_IDX)) cb_pdest (
		.clk(clk), .reset(reset), .alloc1_en(alloc1_en), .alloc2_en(alloc2_en),
		.retire1(retire1_valid), .retire2(retire2_valid), .rewind(branch_miss),
		.tail_new(head_p1), .din1(pdest_in1), .din2(pdest_in2),
		.dout1(pdest_out1), .dout2(pdest_out2)
	);

	cb #(.cb_width(ARF_IDX)) cb_adest (
		.clk(clk), .reset(reset), .alloc1_en(alloc1_en), .alloc2_en(alloc2_en),
		.retire1(retire1_valid), .retire2(retire2_valid), .rewind(branch_miss),
		.tail_new(head_p1), .din1(adest_in1), .din2(adest_in2),
		.dout1(adest_out1), .dout2(adest_out2)
	);

	cb #(.cb_width(XLEN)) cb_ba_pd (
		.clk(clk), .reset(reset), .alloc1_en(alloc1_en), .alloc2_en(alloc2_en),
		.retire1(retire1_valid), .retire2(retire2_valid), .rewind(branch_miss),
		.tail_new(head_p1), .din1(ba_pd_in1), .din2(ba_pd_in2),
		.dout1(ba_pd_out1), .dout2(ba_pd_out2)
	);

	cb #(.cb_width(1)) cb_bt_pd (
		.clk(clk), .reset(reset), .alloc1_en(alloc1_en), .alloc2_en(alloc2_en),
		.retire1(retire1_valid), .retire2(retire2_valid), .rewind(branch_miss),
		.tail_new(head_p1), .din1(bt_pd_in1), .din2(bt_pd_in2),
		.dout1(bt_pd_out1), .dout2(bt_pd_out2)
	);

	cb #(.cb_width(1)) cb_isbranch (
		.clk(clk), .reset(reset), .alloc1_en(alloc1_en), .alloc2_en(alloc2_en),
		.retire1(retire1_valid), .retire2(retire2_valid), .rewind(branch_miss),
		.tail_new(head_p1), .din1(isbranch_in1), .din2(isbranch_in2),
		.dout1(isbranch_out1), .dout2(isbranch_out2)
	);

endmodule

/* source/retire_map.sv */
`timescale 1ns/1ps

// committed architectural to physical register map
module retire_map
	import rob_pkg::*;
(
	input logic clk,
	input logic reset,

	// retiring destinations from the rob
	input logic retire1_valid,
	input logic retire2_valid,
	input logic [PRF_IDX-1:0] pdest_in1,
	input logic [PRF_IDX-1:0] pdest_in2,
	input logic [ARF_IDX-1:0] adest_in1,
	input logic [ARF_IDX-1:0] adest_in2,

	// lookup port
	input logic [ARF_IDX-1:0] map_idx,

	// registers released by this retirement
	output logic free1_valid,
	output logic free2_valid,
	output logic [PRF_IDX-1:0] free_pdest1,
	output logic [PRF_IDX-1:0] free_pdest2,

	output logic [PRF_IDX-1:0] map_pdest
);

	logic [PRF_IDX-1:0] map [ARF_SZ];
	logic same_dest;

	// both slots write the same register in one cycle
	assign same_dest = retire1_valid && retire2_valid && (adest_in1 == adest_in2);

	// ========================================================================
	// freed registers
	// ========================================================================

	assign free1_valid = retire1_valid;
	assign free2_valid = retire2_valid;
	assign free_pdest1 = map[adest_in1];

	// slot 2 replaces what slot 1 just wrote
	assign free_pdest2 = same_dest ? pdest_in1 : map[adest_in2];

	// ========================================================================
	// map update
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			// identity mapping
			for (int i = 0; i < ARF_SZ; i++) begin
				map[i] <= PRF_IDX'(i);
			end
		end else begin
			if (retire1_valid) begin
				map[adest_in1] <= pdest_in1;
			end
			// slot 2 is younger, so it is written last
			if (retire2_valid) begin
				map[adest_in2] <= pdest_in2;
			end
		end
	end

	assign map_pdest = map[map_idx];

endmodule

/* source/rob_top.sv */
`timescale 1ns/1ps

module rob_top
	import rob_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic alloc1_req,
	input logic alloc2_req,
	input logic [IR_W-1:0] ir_in1,
	input logic [IR_W-1:0] ir_in2,
	input logic [XLEN-1:0] npc_in1,
	input logic [XLEN-1:0] npc_in2,
	input logic [PRF_IDX-1:0] pdest_in1,
	input logic [PRF_IDX-1:0] pdest_in2,
	input logic [ARF_IDX-1:0] adest_in1,
	input logic [ARF_IDX-1:0] adest_in2,
	input logic bt_pd_in1,
	input logic bt_pd_in2,
	input logic [XLEN-1:0] ba_pd_in1,
	input logic [XLEN-1:0] ba_pd_in2,
	input logic isbranch_in1,
	input logic isbranch_in2,

	input logic upd1_req,
	input logic upd2_req,
	input logic [ROB_IDX-1:0] rob_idx_in1,
	input logic [ROB_IDX-1:0] rob_idx_in2,
	input logic bt_ex_in1,
	input logic bt_ex_in2,
	input logic [XLEN-1:0] ba_ex_in1,
	input logic [XLEN-1:0] ba_ex_in2,

	input logic [ARF_IDX-1:0] map_idx,

	output logic [ROB_IDX-1:0] rob_idx_out1,
	output logic [ROB_IDX-1:0] rob_idx_out2,
	output logic retire1_valid,
	output logic retire2_valid,
	output logic [IR_W-1:0] ir_out1,
	output logic [IR_W-1:0] ir_out2,
	output logic [XLEN-1:0] npc_out1,
	output logic [XLEN-1:0] npc_out2,
	output logic [PRF_IDX-1:0] pdest_out1,
	output logic [PRF_IDX-1:0] pdest_out2,
	output logic [ARF_IDX-1:0] adest_out1,
	output logic [ARF_IDX-1:0] adest_out2,

	output logic branch_miss,
	output logic [XLEN-1:0] correct_target,
	output logic [1:0] isbranch_out,
	output logic [1:0] bt_out,
	output logic [2*XLEN-1:0] ba_out,

	output logic full,
	output logic full_almost,
	output logic [ROB_IDX-1:0] head,

	output logic free1_valid,
	output logic free2_valid,
	output logic [PRF_IDX-1:0] free_pdest1,
	output logic [PRF_IDX-1:0] free_pdest2,
	output logic [PRF_IDX-1:0] map_pdest
);

	// ========================================================================
	// reorder buffer
	// ========================================================================

	rob u_rob (
		.clk(clk), .reset(reset),
		.alloc1_req(alloc1_req), .alloc2_req(alloc2_req),
		.ir_in1(ir_in1), .ir_in2(ir_in2), .npc_in1(npc_in1), .npc_in2(npc_in2),
		.pdest_in1(pdest_in1), .pdest_in2(pdest_in2),
		.adest_in1(adest_in1), .adest_in2(adest_in2),
		.bt_pd_in1(bt_pd_in1), .bt_pd_in2(bt_pd_in2),
		.ba_pd_in1(ba_pd_in1), .ba_pd_in2(ba_pd_in2),
		.isbranch_in1(isbranch_in1), .isbranch_in2(isbranch_in2),
		.upd1_req(upd1_req), .upd2_req(upd2_req),
		.rob_idx_in1(rob_idx_in1), .rob_idx_in2(rob_idx_in2),
		.bt_ex_in1(bt_ex_in1), .bt_ex_in2(bt_ex_in2),
		.ba_ex_in1(ba_ex_in1), .ba_ex_in2(ba_ex_in2),
		.rob_idx_out1(rob_idx_out1), .rob_idx_out2(rob_idx_out2), .head(head),
		.retire1_valid(retire1_valid), .retire2_valid(retire2_valid),
		.ir_out1(ir_out1), .ir_out2(ir_out2), .npc_out1(npc_out1), .npc_out2(npc_out2),
		.pdest_out1(pdest_out1), .pdest_out2(pdest_out2),
		.adest_out1(adest_out1), .adest_out2(adest_out2),
		.branch_miss(branch_miss), .correct_target(correct_target),
		.isbranch_out(isbranch_out), .bt_out(bt_out), .ba_out(ba_out),
		.full(full), .full_almost(full_almost)
	);

	// ========================================================================
	// commit map, fed straight from the retire ports
	// ========================================================================

	retire_map u_map (
		.clk(clk), .reset(reset),
		.retire1_valid(retire1_valid), .retire2_valid(retire2_valid),
		.pdest_in1(pdest_out1), .pdest_in2(pdest_out2),
		.adest_in1(adest_out1), .adest_in2(adest_out2),
		.map_idx(map_idx),
		.free1_valid(free1_valid), .free2_valid(free2_valid),
		.free_pdest1(free_pdest1), .free_pdest2(free_pdest2),
		.map_pdest(map_pdest)
	);

endmodule

/* bench/rob_assertions.sv */
`timescale 1ns/1ps

// protocol properties of the reorder buffer outputs
module rob_assertions
	import rob_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic retire1_valid,
	input logic retire2_valid,
	input logic branch_miss,
	input logic full,
	input logic full_almost,
	input logic [ROB_IDX-1:0] rob_idx_out1,
	input logic [ROB_IDX-1:0] head
);

	// slot 2 never reads past the tail
	assert property (@(posedge clk) disable iff (reset)
		retire2_valid |-> (head + ROB_IDX'(1) != rob_idx_out1))
		else $error("retire2_valid high with a single entry left");

	// a squashing branch leaves nothing behind it
	assert property (@(posedge clk) disable iff (reset)
		branch_miss |=> !retire1_valid && (rob_idx_out1 == head) && !full)
		else $error("rob not empty after a branch miss");

	// registered flags agree with the pointers
	assert property (@(posedge clk) disable iff (reset)
		full |-> (rob_idx_out1 == head))
		else $error("full high while tail and head differ");

	assert property (@(posedge clk) disable iff (reset)
		full_almost |-> (rob_idx_out1 + ROB_IDX'(1) == head))
		else $error("full_almost high while more than one entry is free");

endmodule

bind rob rob_assertions u_rob_assertions (
	.clk(clk),
	.reset(reset),
	.retire1_valid(retire1_valid),
	.retire2_valid(retire2_valid),
	.branch_miss(branch_miss),
	.full(full),
	.full_almost(full_almost),
	.rob_idx_out1(rob_idx_out1),
	.head(head)
);

/* bench/rob_tb.sv */
`timescale 1ns/1ps

module rob_tb
	import rob_pkg::*;
;

	typedef struct {
		string name;
		int n_alloc;
		logic [1:0] isb;
		logic bt_pd;
		logic [63:0] ba_pd;
		logic same_ad;
		int n_upd;
		int idx1;
		int idx2;
		logic bt_ex;
		logic [63:0] ba_ex;
		int exp_ret;
		logic exp_miss;
		logic [63:0] exp_tgt;
		logic exp_full;
		logic exp_fa;
	} row_t;

	typedef struct {
		int idx;
		logic [IR_W-1:0] ir;
		logic [XLEN-1:0] npc;
		logic [PRF_IDX-1:0] pd;
		logic [ARF_IDX-1:0] ad;
		logic isb;
		logic bt_ex;
		logic [XLEN-1:0] ba_ex;
	} entry_t;

	logic clk = 1'b0;
	logic reset;
	logic alloc1_req, alloc2_req;
	logic [IR_W-1:0] ir_in1, ir_in2;
	logic [XLEN-1:0] npc_in1, npc_in2;
	logic [PRF_IDX-1:0] pdest_in1, pdest_in2;
	logic [ARF_IDX-1:0] adest_in1, adest_in2;
	logic bt_pd_in1, bt_pd_in2;
	logic [XLEN-1:0] ba_pd_in1, ba_pd_in2;
	logic isbranch_in1, isbranch_in2;
	logic upd1_req, upd2_req;
	logic [ROB_IDX-1:0] rob_idx_in1, rob_idx_in2;
	logic bt_ex_in1, bt_ex_in2;
	logic [XLEN-1:0] ba_ex_in1, ba_ex_in2;
	logic [ARF_IDX-1:0] map_idx;

	logic [ROB_IDX-1:0] rob_idx_out1, rob_idx_out2, head;
	logic retire1_valid, retire2_valid;
	logic [IR_W-1:0] ir_out1, ir_out2;
	logic [XLEN-1:0] npc_out1, npc_out2;
	logic [PRF_IDX-1:0] pdest_out1, pdest_out2;
	logic [ARF_IDX-1:0] adest_out1, adest_out2;
	logic branch_miss;
	logic [XLEN-1:0] correct_target;
	logic [1:0] isbranch_out, bt_out;
	logic [2*XLEN-1:0] ba_out;
	logic full, full_almost;
	logic free1_valid, free2_valid;
	logic [PRF_IDX-1:0] free_pdest1, free_pdest2, map_pdest;

	row_t rows[$];
	entry_t q[$];
	logic [PRF_IDX-1:0] amap [ARF_SZ];
	logic [ARF_IDX-1:0] map_sel = '0;
	logic [31:0] lfsr = 32'd32931;
	int tail_m = 0;
	int head_m = 0;
	int errors = 0;
	int checks = 0;
	logic table_ready = 1'b0;

	rob_top DUT (.*);

	always #2 clk = ~clk;

	// ========================================================================
	// helpers
	// ========================================================================

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check_val(input string test, input string what,
			input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Mismatch %s %s: expected %0h, actual %0h", test, what, exp, act);
		end
	endtask

	task automatic add_row(input string name, input int n_alloc, input logic [1:0] isb,
			input logic bt_pd, input logic [63:0] ba_pd, input logic same_ad,
			input int n_upd, input int idx1, input int idx2, input logic bt_ex,
			input logic [63:0] ba_ex, input int exp_ret, input logic exp_miss,
			input logic [63:0] exp_tgt, input logic exp_full, input logic exp_fa);
		row_t r;
		r = '{name, n_alloc, isb, bt_pd, ba_pd, same_ad, n_upd, idx1, idx2, bt_ex, ba_ex,
			exp_ret, exp_miss, exp_tgt, exp_full, exp_fa};
		rows.push_back(r);
	endtask

	// ========================================================================
	// stimulus table, one row per cycle
	// ========================================================================

	task automatic build_table();
		// in-order retirement after out-of-order completion
		add_row("alloc_a", 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row("alloc_b", 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row("upd_young_first", 0, 0, 0, 0, 0, 2, 3, 2, 0, 0, 0, 0, 0, 0, 0);
		add_row("upd_head_pair", 0, 0, 0, 0, 0, 2, 1, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row("retire_pair1", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0, 0, 0, 0);
		add_row("retire_pair2", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0, 0, 0, 0);
		add_row("idle_a", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		// back-pressure
		for (int i = 0; i < 7; i++) begin
			add_row($sformatf("fill_%0d", i), 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		end
		add_row("fill_one", 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row("fill_at_almost", 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row("push_when_full", 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0);
		add_row("still_full", 1, 0, 0, 0, 0, 2, 4, 5, 0, 0, 0, 0, 0, 1, 0);
		add_row("drain_0", 0, 0, 0, 0, 0, 2, 6, 7, 0, 0, 2, 0, 0, 1, 0);
		for (int i = 1; i < 7; i++) begin
			add_row($sformatf("drain_%0d", i), 0, 0, 0, 0, 0, 2, (2 * i + 6) % 16,
				(2 * i + 7) % 16, 0, 0, 2, 0, 0, 0, 0);
		end
		add_row("drain_last", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0, 0, 0, 0);
		add_row("idle_b", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		// slot 1 misprediction squashes younger completed entries
		add_row("alloc_br", 2, 2'b01, 1, 64'h100, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row("alloc_young", 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row("upd_young", 0, 0, 0, 0, 0, 2, 6, 7, 0, 0, 0, 0, 0, 0, 0);
		add_row("upd_br_miss", 0, 0, 0, 0, 0, 1, 4, 0, 1, 64'h200, 0, 0, 0, 0, 0);
		add_row("branch_miss", 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 64'h200, 0, 0);
		add_row("after_miss", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		// slot 2 misprediction waits for slot 1
		add_row("alloc_br2", 2, 2'b10, 0, 64'h300, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row("upd_pair", 0, 0, 0, 0, 0, 2, 5, 6, 1, 64'h300, 0, 0, 0, 0, 0);
		add_row("slot2_held", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0);
		add_row("slot2_miss", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 64'h300, 0, 0);
		add_row("idle_c", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		// correct prediction, both slots on one register
		add_row("alloc_good_br", 2, 2'b01, 1, 64'h400, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row("upd_good", 0, 0, 0, 0, 0, 2, 7, 8, 1, 64'h400, 0, 0, 0, 0, 0);
		add_row("retire_good", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0, 0, 0, 0);
		add_row("idle_end", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	endtask

	// ========================================================================
	// drive, check and model update
	// ========================================================================

	task automatic drive_row(input row_t r);
		alloc1_req = (r.n_alloc >= 1);
		alloc2_req = (r.n_alloc == 2);
		ir_in1 = IR_W'(rand_bits(32));
		ir_in2 = IR_W'(rand_bits(32));
		npc_in1 = rand_bits(64);
		npc_in2 = rand_bits(64);
		pdest_in1 = PRF_IDX'(rand_bits(6));
		pdest_in2 = PRF_IDX'(rand_bits(6));
		adest_in1 = ARF_IDX'(rand_bits(5));
		adest_in2 = r.same_ad ? adest_in1 : ARF_IDX'(rand_bits(5));
		isbranch_in1 = r.isb[0];
		isbranch_in2 = r.isb[1];
		bt_pd_in1 = r.bt_pd;
		bt_pd_in2 = r.bt_pd;
		ba_pd_in1 = r.ba_pd;
		ba_pd_in2 = r.ba_pd;
		upd1_req = (r.n_upd >= 1);
		upd2_req = (r.n_upd == 2);
		rob_idx_in1 = ROB_IDX'(r.idx1);
		rob_idx_in2 = ROB_IDX'(r.idx2);
		bt_ex_in1 = r.bt_ex;
		bt_ex_in2 = r.bt_ex;
		ba_ex_in1 = r.ba_ex;
		ba_ex_in2 = r.ba_ex;
		// look up the register retired last
		map_idx = map_sel;
	endtask

	task automatic check_and_step(input row_t r);
		entry_t e;
		int cnt_reg;
		logic [PRF_IDX-1:0] exp_free;
		logic a1_ok;
		check_val(r.name, "retire1_valid", 64'(r.exp_ret >= 1), 64'(retire1_valid));
		check_val(r.name, "retire2_valid", 64'(r.exp_ret == 2), 64'(retire2_valid));
		check_val(r.name, "branch_miss", 64'(r.exp_miss), 64'(branch_miss));
		check_val(r.name, "correct_target", r.exp_tgt, correct_target);
		check_val(r.name, "full", 64'(r.exp_full), 64'(full));
		check_val(r.name, "full_almost", 64'(r.exp_fa), 64'(full_almost));
		check_val(r.name, "rob_idx_out1", 64'(tail_m % ROB_SZ), 64'(rob_idx_out1));
		check_val(r.name, "rob_idx_out2", 64'((tail_m + 1) % ROB_SZ), 64'(rob_idx_out2));
		check_val(r.name, "head", 64'(head_m % ROB_SZ), 64'(head));
		check_val(r.name, "map_pdest", 64'(amap[map_idx]), 64'(map_pdest));
		check_val(r.name, "free1_valid", 64'(r.exp_ret >= 1), 64'(free1_valid));
		check_val(r.name, "free2_valid", 64'(r.exp_ret == 2), 64'(free2_valid));
		for (int k = 0; k < r.exp_ret && k < q.size(); k++) begin
			e = q[k];
			check_val(r.name, "ir", 64'(e.ir), 64'(k == 0 ? ir_out1 : ir_out2));
			check_val(r.name, "npc", e.npc, k == 0 ? npc_out1 : npc_out2);
			check_val(r.name, "pdest", 64'(e.pd), 64'(k == 0 ? pdest_out1 : pdest_out2));
			check_val(r.name, "adest", 64'(e.ad), 64'(k == 0 ? adest_out1 : adest_out2));
			check_val(r.name, "isbranch_out", 64'(e.isb),
				64'(k == 0 ? isbranch_out[1] : isbranch_out[0]));
			if (e.isb) begin
				check_val(r.name, "bt_out", 64'(e.bt_ex), 64'(k == 0 ? bt_out[1] : bt_out[0]));
				check_val(r.name, "ba_out", e.ba_ex, k == 0 ? ba_out[127:64] : ba_out[63:0]);
			end
			// commit map, slot 2 sees slot 1's write
			exp_free = amap[e.ad];
			amap[e.ad] = e.pd;
			map_sel = e.ad;
			check_val(r.name, "free_pdest", 64'(exp_free),
				64'(k == 0 ? free_pdest1 : free_pdest2));
		end
		cnt_reg = q.size();
		if (r.exp_miss && q.size() > 0) begin
			tail_m = q[0].idx + 1;
			head_m = tail_m;
			q.delete();
		end else begin
			for (int k = 0; k < r.exp_ret && q.size() > 0; k++) begin
				void'(q.pop_front());
				head_m++;
			end
			// allocation against the registered occupancy
			a1_ok = (r.n_alloc >= 1) && (cnt_reg < ROB_SZ);
			for (int a = 0; a < r.n_alloc; a++) begin
				if (a1_ok && (a == 0 || cnt_reg != ROB_SZ - 1)) begin
					e.idx = tail_m % ROB_SZ;
					e.ir = (a == 0) ? ir_in1 : ir_in2;
					e.npc = (a == 0) ? npc_in1 : npc_in2;
					e.pd = (a == 0) ? pdest_in1 : pdest_in2;
					e.ad = (a == 0) ? adest_in1 : adest_in2;
					e.isb = r.isb[a];
					e.bt_ex = 1'b0;
					e.ba_ex = '0;
					q.push_back(e);
					tail_m++;
				end
			end
		end
		for (int u = 0; u < r.n_upd; u++) begin
			foreach (q[j]) begin
				if (q[j].idx == ((u == 0) ? r.idx1 : r.idx2)) begin
					q[j].bt_ex = r.bt_ex;
					q[j].ba_ex = r.ba_ex;
				end
			end
		end
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================

	initial begin
		reset = 1'b1;
		alloc1_req = 0;
		alloc2_req = 0;
		ir_in1 = '0;
		ir_in2 = '0;
		npc_in1 = '0;
		npc_in2 = '0;
		pdest_in1 = '0;
		pdest_in2 = '0;
		adest_in1 = '0;
		adest_in2 = '0;
		bt_pd_in1 = 0;
		bt_pd_in2 = 0;
		ba_pd_in1 = '0;
		ba_pd_in2 = '0;
		isbranch_in1 = 0;
		isbranch_in2 = 0;
		upd1_req = 0;
		upd2_req = 0;
		rob_idx_in1 = '0;
		rob_idx_in2 = '0;
		bt_ex_in1 = 0;
		bt_ex_in2 = 0;
		ba_ex_in1 = '0;
		ba_ex_in2 = '0;
		map_idx = '0;
		build_table();
		table_ready = 1'b1;
		for (int i = 0; i < ARF_SZ; i++) begin
			amap[i] = PRF_IDX'(i);
		end
		repeat (5) @(posedge clk);
		#0.5 reset = 1'b0;

		// state right after reset, identity map
		check_val("reset", "retire1_valid", 0, 64'(retire1_valid));
		check_val("reset", "retire2_valid", 0, 64'(retire2_valid));
		check_val("reset", "branch_miss", 0, 64'(branch_miss));
		check_val("reset", "full", 0, 64'(full));
		for (int i = 0; i < ARF_SZ; i++) begin
			@(posedge clk);
			#0.5;
			map_idx = ARF_IDX'(i);
			@(negedge clk);
			check_val("reset", "map_pdest", 64'(i), 64'(map_pdest));
		end

		foreach (rows[i]) begin
			@(posedge clk);
			#0.5;
			drive_row(rows[i]);
			@(negedge clk);
			check_and_step(rows[i]);
		end

		@(posedge clk);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		$finish;
	end

	// watchdog sized from the table and the map sweep
	initial begin
		wait (table_ready);
		#((rows.size() + ARF_SZ) * 4 * 4 + 40);
		$display("timeout: the table did not finish in time");
		$display("Some tests failed");
		$finish;
	end

endmodule

/* rob_subsystem.f */
source/rob_pkg.sv
source/cb.sv
source/rob.sv
source/retire_map.sv
source/rob_top.sv
bench/rob_assertions.sv
bench/rob_tb.sv

/* run.sh */
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f rob_subsystem.f --top-module rob_tb -o rob_tb_sim

./obj_dir/rob_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
if ! grep -q "All tests passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
